// File: Bender.yml
package:
  name: integ_adc

sources:
  # RTL in compile order
  - files:
      - logic/integ_adc_pkg.sv
      - logic/spi_frame_port.sv
      - logic/runup_sequencer.sv
      - logic/adc_reg_file.sv
      - logic/integ_adc_top.sv
  # testbench and bound assertions
  - target: test
    files:
      - verification/integ_adc_chk.sv
      - verification/integ_adc_tb.sv

// File: integ_adc.f
logic/integ_adc_pkg.sv
logic/spi_frame_port.sv
logic/runup_sequencer.sv
logic/adc_reg_file.sv
logic/integ_adc_top.sv
verification/integ_adc_chk.sv
verification/integ_adc_tb.sv

// File: logic/adc_reg_file.sv
// host register file.
// LED set/clear/toggle update and LED soft reset.
// start pulse and runup length.
// result capture, status byte and interrupt.
// read data mux for the SPI port.

`timescale 1ns/1ps

module adc_reg_file (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        addr_strobe,
  input  logic [7:0]                  addr,
  input  logic                        frame_strobe,
  input  integ_adc_pkg::spi_frame_t   frame,
  input  logic                        result_strobe,
  input  integ_adc_pkg::conv_result_t result,
  input  logic                        busy,
  output logic [7:0]                  rd_data,
  output logic                        start,
  output integ_adc_pkg::conv_cfg_t    cfg,
  output logic [3:0]                  led,
  output logic                        irq
);
  import integ_adc_pkg::*;

  logic [7:0]   runup_phases;
  logic         ready;
  conv_result_t result_q;

  // low nibble sets, high nibble clears, both toggles.
  function automatic logic [3:0] led_next(input logic [3:0] cur, input logic [7:0] data);
    logic [3:0] set_bits;
    logic [3:0] clr_bits;
    set_bits = data[3:0];
    clr_bits = data[7:4];
    return ((cur | set_bits) & ~clr_bits) | (~cur & set_bits & clr_bits);
  endfunction

  //////////////////////////////////////////////////
  // writes from completed frames.
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      led          <= '0;
      runup_phases <= DEFAULT_PHASES;
      start        <= 1'b0;
    end
    else
    begin
      // one cycle pulse, the sequencer drops it when busy.
      start <= frame_strobe && (frame.addr == ADDR_CTRL) && frame.data[0];
      if (frame_strobe)
      begin
        case (frame.addr)
          ADDR_LED:       led <= led_next(led, frame.data);
          ADDR_LED_RESET: led <= LED_RESET_VAL;
          ADDR_PHASES:    runup_phases <= frame.data;
          default:        ;
        endcase
      end
    end
  end

  assign cfg.runup_phases = runup_phases;

  //////////////////////////////////////////////////
  // result capture and status.
  //////////////////////////////////////////////////

  // a new result overwrites an unread one.
  always_ff @(posedge clk)
  begin
    if (result_strobe)
      result_q <= result;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      ready <= 1'b0;
    else if (result_strobe)
      ready <= 1'b1;
    // any completed frame to the status byte acknowledges.
    else if (frame_strobe && (frame.addr == ADDR_STATUS))
      ready <= 1'b0;
  end

  assign irq = ready;

  //////////////////////////////////////////////////
  // read mux.
  //////////////////////////////////////////////////

  // sampled by the port only during addr_strobe.
  always_comb
  begin
    rd_data = 8'h00;
    if (addr_strobe)
    begin
      case (addr)
        ADDR_LED:        rd_data = {4'h0, led};
        ADDR_PHASES:     rd_data = runup_phases;
        ADDR_UP_LO:      rd_data = result_q.count_up[7:0];
        ADDR_UP_HI:      rd_data = result_q.count_up[15:8];
        ADDR_DOWN_LO:    rd_data = result_q.count_down[7:0];
        ADDR_DOWN_HI:    rd_data = result_q.count_down[15:8];
        ADDR_RUNDOWN_LO: rd_data = result_q.count_rundown[7:0];
        ADDR_RUNDOWN_HI: rd_data = result_q.count_rundown[15:8];
        ADDR_STATUS:     rd_data = {6'b0, busy, ready};
        default:         rd_data = 8'h00;
      endcase
    end
  end

endmodule

// File: logic/integ_adc_pkg.sv
// shared definitions for the integrating ADC controller.
// counter width, register addresses and the LED reset value.
// integrator switch codes.
// packed structs for SPI frames, conversion settings and results.

package integ_adc_pkg;

  //////////////////////////////////////////////////
  // widths and register map.
  //////////////////////////////////////////////////

  // every conversion counter has this width.
  localparam int COUNT_W = 16;

  // host register addresses.
  localparam logic [7:0] ADDR_LED        = 8'h07;
  localparam logic [7:0] ADDR_CTRL       = 8'h08;
  localparam logic [7:0] ADDR_PHASES     = 8'h09;
  localparam logic [7:0] ADDR_LED_RESET  = 8'h0B;
  localparam logic [7:0] ADDR_UP_LO      = 8'h10;
  localparam logic [7:0] ADDR_UP_HI      = 8'h11;
  localparam logic [7:0] ADDR_DOWN_LO    = 8'h12;
  localparam logic [7:0] ADDR_DOWN_HI    = 8'h13;
  localparam logic [7:0] ADDR_RUNDOWN_LO = 8'h14;
  localparam logic [7:0] ADDR_RUNDOWN_HI = 8'h15;
  localparam logic [7:0] ADDR_STATUS     = 8'h16;

  // value loaded by a write to the LED reset address.
  localparam logic [3:0] LED_RESET_VAL = 4'b0101;
  // runup length after reset, in phases.
  localparam logic [7:0] DEFAULT_PHASES = 8'd8;

  //////////////////////////////////////////////////
  // integrator switch code.
  //////////////////////////////////////////////////

  // bit 2 connects the input, bit 1 pushes down, bit 0 pushes up.
  typedef logic [2:0] mux_code_t;
  localparam mux_code_t MUX_IDLE  = 3'b000;
  localparam mux_code_t MUX_UP    = 3'b001;
  localparam mux_code_t MUX_DOWN  = 3'b010;
  localparam mux_code_t MUX_INPUT = 3'b100;

  // one complete write frame, address byte first on the wire.
  typedef struct packed {
    logic [7:0] addr;
    logic [7:0] data;
  } spi_frame_t;

  // settings handed to the sequencer.
  typedef struct packed {
    logic [7:0] runup_phases;
  } conv_cfg_t;

  // the three counts of one conversion.
  typedef struct packed {
    logic [COUNT_W-1:0] count_up;
    logic [COUNT_W-1:0] count_down;
    logic [COUNT_W-1:0] count_rundown;
  } conv_result_t;

endpackage

// File: logic/integ_adc_top.sv
// top level of the integrating ADC controller.
// SPI port, register file and conversion sequencer.

`timescale 1ns/1ps

module integ_adc_top #(
  parameter int PHASE_CLOCKS = 20,
  parameter int SYNC_STAGES  = 2
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     sclk,
  input  logic                     cs_n,
  input  logic                     mosi,
  input  logic                     cmp,
  output logic                     miso,
  output logic                     irq,
  output logic [3:0]               led,
  output integ_adc_pkg::mux_code_t mux
);
  import integ_adc_pkg::*;

  // port to register file.
  logic         addr_strobe;
  logic [7:0]   addr;
  logic [7:0]   rd_data;
  logic         frame_strobe;
  spi_frame_t   frame;
  // register file and sequencer.
  logic         start;
  conv_cfg_t    cfg;
  logic         busy;
  logic         result_strobe;
  conv_result_t result;

  //////////////////////////////////////////////////
  // instances.
  //////////////////////////////////////////////////

  spi_frame_port #(
    .SYNC_STAGES (SYNC_STAGES)
  ) u_spi (
    .clk          (clk),
    .rst_n        (rst_n),
    .sclk         (sclk),
    .cs_n         (cs_n),
    .mosi         (mosi),
    .rd_data      (rd_data),
    .miso         (miso),
    .addr_strobe  (addr_strobe),
    .addr         (addr),
    .frame_strobe (frame_strobe),
    .frame        (frame)
  );

  runup_sequencer #(
    .PHASE_CLOCKS (PHASE_CLOCKS),
    .SYNC_STAGES  (SYNC_STAGES)
  ) u_seq (
    .clk           (clk),
    .rst_n         (rst_n),
    .start         (start),
    .cfg           (cfg),
    .cmp           (cmp),
    .mux           (mux),
    .busy          (busy),
    .result_strobe (result_strobe),
    .result        (result)
  );

  adc_reg_file u_regs (
    .clk           (clk),
    .rst_n         (rst_n),
    .addr_strobe   (addr_strobe),
    .addr          (addr),
    .frame_strobe  (frame_strobe),
    .frame         (frame),
    .result_strobe (result_strobe),
    .result        (result),
    .busy          (busy),
    .rd_data       (rd_data),
    .start         (start),
    .cfg           (cfg),
    .led           (led),
    .irq           (irq)
  );

endmodule

// File: logic/runup_sequencer.sv
// multi-slope conversion sequencer.
// comparator synchronizer and edge detect.
// idle, runup, rundown and done states.
// phase timing and the up, down and rundown counters.

`timescale 1ns/1ps

module runup_sequencer #(
  parameter int PHASE_CLOCKS = 20,
  parameter int SYNC_STAGES  = 2
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        start,
  input  integ_adc_pkg::conv_cfg_t    cfg,
  input  logic                        cmp,
  output integ_adc_pkg::mux_code_t    mux,
  output logic                        busy,
  output logic                        result_strobe,
  output integ_adc_pkg::conv_result_t result
);
  import integ_adc_pkg::*;

  localparam int               CLK_W    = $clog2(PHASE_CLOCKS + 1);
  localparam logic [CLK_W-1:0] LAST_CLK = CLK_W'(PHASE_CLOCKS - 1);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_RUNUP,
    ST_RUNDOWN,
    ST_DONE
  } state_t;

  state_t             state;
  logic [SYNC_STAGES-1:0] cmp_sync;
  logic               cmp_s;
  logic               cmp_d;
  logic               cmp_edge;
  logic [CLK_W-1:0]   clk_cnt;
  logic [7:0]         phase_cnt;
  // runup length is latched at start.
  logic [7:0]         phases_q;
  logic               phase_end;
  logic               last_phase;
  mux_code_t          next_dir;
  logic [COUNT_W-1:0] count_up;
  logic [COUNT_W-1:0] count_down;
  logic [COUNT_W-1:0] count_rundown;

  //////////////////////////////////////////////////
  // comparator synchronizer.
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cmp_sync <= '0;
      cmp_d    <= 1'b0;
    end
    else
    begin
      cmp_sync <= SYNC_STAGES'({cmp_sync, cmp});
      cmp_d    <= cmp_s;
    end
  end

  assign cmp_s = cmp_sync[SYNC_STAGES-1];
  // either crossing direction ends the rundown.
  assign cmp_edge = cmp_s ^ cmp_d;

  assign phase_end  = (clk_cnt == LAST_CLK);
  // a length of 0 wraps and runs 256 phases.
  assign last_phase = (phase_cnt == phases_q - 8'd1);
  // comparator high means integrator above zero, so push down.
  assign next_dir   = cmp_s ? MUX_DOWN : MUX_UP;

  //////////////////////////////////////////////////
  // state machine and counters.
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state         <= ST_IDLE;
      mux           <= MUX_IDLE;
      clk_cnt       <= '0;
      phase_cnt     <= '0;
      phases_q      <= '0;
      count_up      <= '0;
      count_down    <= '0;
      count_rundown <= '0;
    end
    else
    begin
      case (state)
        ST_IDLE:
        begin
          // start is only looked at here, so a start while busy is lost.
          if (start)
          begin
            state         <= ST_RUNUP;
            mux           <= MUX_INPUT | MUX_UP;
            clk_cnt       <= '0;
            phase_cnt     <= '0;
            phases_q      <= cfg.runup_phases;
            count_up      <= '0;
            count_down    <= '0;
            count_rundown <= '0;
          end
        end

        ST_RUNUP:
        begin
          clk_cnt <= phase_end ? '0 : clk_cnt + 1'b1;
          if (phase_end)
          begin
            phase_cnt <= phase_cnt + 8'd1;
            if (cmp_s)
              count_up <= count_up + 1'b1;
            else
              count_down <= count_down + 1'b1;
            // last phase drops the input and keeps the new direction.
            if (last_phase)
            begin
              state <= ST_RUNDOWN;
              mux   <= next_dir;
            end
            else
              mux <= MUX_INPUT | next_dir;
          end
        end

        ST_RUNDOWN:
        begin
          count_rundown <= count_rundown + 1'b1;
          if (cmp_edge)
          begin
            mux   <= MUX_IDLE;
            state <= ST_DONE;
          end
        end

        ST_DONE:
          state <= ST_IDLE;

        default:
          state <= ST_IDLE;
      endcase
    end
  end

  assign busy          = (state != ST_IDLE);
  assign result_strobe = (state == ST_DONE);
  assign result        = {count_up, count_down, count_rundown};

endmodule

// File: logic/spi_frame_port.sv
// SPI slave port, oversampled in the system clock.
// pin synchronizers and sclk/cs_n edge detection.
// 16-bit frame deserializer with address fetch after the first byte.
// read data serializer on miso.

`timescale 1ns/1ps

module spi_frame_port #(
  parameter int SYNC_STAGES = 2
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      sclk,
  input  logic                      cs_n,
  input  logic                      mosi,
  input  logic [7:0]                rd_data,
  output logic                      miso,
  output logic                      addr_strobe,
  output logic [7:0]                addr,
  output logic                      frame_strobe,
  output integ_adc_pkg::spi_frame_t frame
);
  import integ_adc_pkg::*;

  // pins travel together as {sclk, cs_n, mosi}; cs_n idles high.
  localparam logic [2:0] PIN_IDLE = 3'b010;

  logic [SYNC_STAGES-1:0][2:0] pin_sync;
  logic                        sclk_s;
  logic                        cs_s;
  logic                        mosi_s;
  logic                        sclk_d;
  logic                        cs_d;
  logic                        sclk_rise;
  logic                        sclk_fall;
  logic                        cs_rise;
  // bit counter saturates at 17 so long frames never alias to 16.
  logic [4:0]                  bit_cnt;
  logic [15:0]                 rx_shift;
  logic [7:0]                  tx_shift;

  //////////////////////////////////////////////////
  // synchronizers and edge detect.
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      pin_sync <= {SYNC_STAGES{PIN_IDLE}};
      sclk_d   <= 1'b0;
      cs_d     <= 1'b1;
    end
    else
    begin
      pin_sync[0] <= {sclk, cs_n, mosi};
      for (int i = 1; i < SYNC_STAGES; i++)
      begin
        pin_sync[i] <= pin_sync[i-1];
      end
      sclk_d <= sclk_s;
      cs_d   <= cs_s;
    end
  end

  assign {sclk_s, cs_s, mosi_s} = pin_sync[SYNC_STAGES-1];

  // sclk edges only count while the frame is selected.
  assign sclk_rise = sclk_s & ~sclk_d & ~cs_s;
  assign sclk_fall = ~sclk_s & sclk_d & ~cs_s;
  assign cs_rise   = cs_s & ~cs_d;

  //////////////////////////////////////////////////
  // receive side.
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      bit_cnt      <= '0;
      addr_strobe  <= 1'b0;
      frame_strobe <= 1'b0;
    end
    else
    begin
      // eighth rising edge completes the address byte.
      addr_strobe  <= sclk_rise && (bit_cnt == 5'd7);
      // compare uses the count before the clear below.
      frame_strobe <= cs_rise && (bit_cnt == 5'd16);
      if (cs_s)
        bit_cnt <= '0;
      else if (sclk_rise && (bit_cnt <= 5'd16))
        bit_cnt <= bit_cnt + 5'd1;
    end
  end

  // msb first, shifted in on sclk rise.
  always_ff @(posedge clk)
  begin
    if (sclk_rise)
      rx_shift <= {rx_shift[14:0], mosi_s};
  end

  // valid while addr_strobe is high, shifter is still between bits.
  assign addr  = rx_shift[7:0];
  // shifter is frozen once cs_n is high.
  assign frame = spi_frame_t'(rx_shift);

  //////////////////////////////////////////////////
  // transmit side.
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tx_shift <= '0;
      miso     <= 1'b0;
    end
    else if (cs_s)
      miso <= 1'b0;
    else if (addr_strobe)
      tx_shift <= rd_data;
    else if (sclk_fall && (bit_cnt >= 5'd8) && (bit_cnt < 5'd16))
    begin
      // falls 8 to 15 put data bits 7 down to 0 on miso.
      miso     <= tx_shift[7];
      tx_shift <= {tx_shift[6:0], 1'b0};
    end
  end

endmodule

// File: verification/integ_adc_chk.sv
// concurrent assertions for the integrating ADC controller.
// mux code legality and idle mux outside a conversion.
// result strobe width and frame strobe timing against cs_n.

`timescale 1ns/1ps

module integ_adc_chk (
  input logic                     clk,
  input logic                     rst_n,
  input logic                     cs_n,
  input integ_adc_pkg::mux_code_t mux,
  input logic                     busy,
  input logic                     result_strobe,
  input logic                     frame_strobe
);
  import integ_adc_pkg::*;

  // both references at once would short them through the integrator.
  a_push_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(mux[0] && mux[1]))
    else $error("mux pushes up and down in the same cycle");

  // one cycle only.
  a_result_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    result_strobe |=> !result_strobe)
    else $error("result_strobe held longer than one cycle");

  a_idle_mux: assert property (@(posedge clk) disable iff (!rst_n)
    !busy |-> (mux == MUX_IDLE))
    else $error("mux not idle while the sequencer is idle");

  // a frame only completes once the host has released cs_n.
  a_frame_deselected: assert property (@(posedge clk) disable iff (!rst_n)
    frame_strobe |-> cs_n)
    else $error("frame_strobe while cs_n is low");

endmodule

// sequencer and SPI port signals all meet at the top level.
bind integ_adc_top integ_adc_chk u_chk (
  .clk           (clk),
  .rst_n         (rst_n),
  .cs_n          (cs_n),
  .mux           (mux),
  .busy          (busy),
  .result_strobe (result_strobe),
  .frame_strobe  (frame_strobe)
);

// File: verification/integ_adc_tb.sv
// testbench for the integrating ADC controller.
// clock, reset, SPI host tasks and an integrator model that drives cmp.
// reference functions for the LED rule and the conversion counts.
// compare process, error count and watchdog.

`timescale 1ns/1ps

module integ_adc_tb;
  import integ_adc_pkg::*;

  localparam int PHASE_CLOCKS = 20;
  localparam int SYNC_STAGES  = 2;
  // pin change to synchronized value seen by the sequencer.
  localparam int CMP_DELAY    = SYNC_STAGES + 1;
  localparam int REF_STEP     = 1000;
  localparam int VIN_MAX      = 700;
  localparam int MAX_PHASES   = 16;
  // long enough that two frames fit inside one conversion.
  localparam int LONG_PHASES  = 40;
  localparam int N_CONV       = 10;
  localparam int N_FRAMES     = 120;
  // 17 bits of 8 clocks plus the gaps around cs_n.
  localparam int FRAME_CLOCKS = 17 * 8 + 16;
  localparam int IRQ_WAIT     = (LONG_PHASES + 4) * PHASE_CLOCKS * 2;
  localparam int WATCHDOG_CLOCKS = N_CONV * (LONG_PHASES + 4) * PHASE_CLOCKS
                                 + N_FRAMES * FRAME_CLOCKS + 2000;
  localparam int EXPECT_LIMIT = 100000;
  localparam logic [31:0] SEED = 32'h033a_74ce;

  logic        clk;
  logic        rst_n;
  logic        sclk;
  logic        cs_n;
  logic        mosi;
  logic        cmp;
  logic        miso;
  logic        irq;
  logic [3:0]  led;
  mux_code_t   mux;

  // integrator model state.
  int          acc;
  int          cur_vin;
  int          n_checks;
  int          n_errors;
  // pending comparisons, drained by the compare process.
  string       name_q[$];
  logic [31:0] got_q[$];
  logic [31:0] exp_q[$];

  integ_adc_top #(
    .PHASE_CLOCKS (PHASE_CLOCKS),
    .SYNC_STAGES  (SYNC_STAGES)
  ) u_integ_adc_top (
    .clk   (clk),
    .rst_n (rst_n),
    .sclk  (sclk),
    .cs_n  (cs_n),
    .mosi  (mosi),
    .cmp   (cmp),
    .miso  (miso),
    .irq   (irq),
    .led   (led),
    .mux   (mux)
  );

  //////////////////////////////////////////////////
  // clock, watchdog, model and compare process.
  //////////////////////////////////////////////////

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial
  begin
    repeat (WATCHDOG_CLOCKS) @(posedge clk);
    $display("watchdog expired after %0d clocks before the tests finished", WATCHDOG_CLOCKS);
    $display("Test failed");
    $finish;
  end

  // integrator charge added in one clock for a given switch code.
  function automatic int mux_step(input mux_code_t m, input int vin);
    int delta;
    delta = 0;
    if (m[2])
      delta += vin;
    if (m[0])
      delta += REF_STEP;
    if (m[1])
      delta -= REF_STEP;
    return delta;
  endfunction

  // comparator is high while the integrator is above zero.
  always @(negedge clk)
  begin
    acc = acc + mux_step(mux, cur_vin);
    cmp = (acc > 0);
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    n_checks++;
    if (got !== exp)
    begin
      n_errors++;
      $display("ERROR %0t: %s got 0x%0h, expected 0x%0h", $time, name, got, exp);
    end
  endtask

  always @(posedge clk)
  begin
    while (got_q.size() > 0)
      check_value(name_q.pop_front(), got_q.pop_front(), exp_q.pop_front());
  end

  task automatic expect_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    name_q.push_back(name);
    got_q.push_back(got);
    exp_q.push_back(exp);
  endtask

  //////////////////////////////////////////////////
  // reference functions.
  //////////////////////////////////////////////////

  // per bit: low nibble sets, high nibble clears, both toggles.
  function automatic logic [3:0] led_update(input logic [3:0] cur, input logic [7:0] data);
    logic [3:0] next;
    for (int i = 0; i < 4; i++)
    begin
      if (data[i] && data[i+4])
        next[i] = ~cur[i];
      else if (data[i])
        next[i] = 1'b1;
      else if (data[i+4])
        next[i] = 1'b0;
      else
        next[i] = cur[i];
    end
    return next;
  endfunction

  // step t is the mux code that follows clock t of the conversion.
  function automatic conv_result_t conv_expect(input int vin, input int phases);
    conv_result_t r;
    bit           hist[$];
    int           level;
    int           done_phases;
    bit           rundown;
    bit           c_now;
    bit           c_old;
    mux_code_t    m;
    r           = '0;
    level       = 0;
    done_phases = 0;
    rundown     = 1'b0;
    m           = MUX_INPUT | MUX_UP;
    for (int t = 0; t < EXPECT_LIMIT; t++)
    begin
      // comparator as the sequencer sees it, and one clock older.
      c_now = (t >= CMP_DELAY) ? hist[t-CMP_DELAY] : 1'b0;
      c_old = (t > CMP_DELAY) ? hist[t-CMP_DELAY-1] : 1'b0;
      if (rundown)
      begin
        r.count_rundown = r.count_rundown + 1'b1;
        if (c_now != c_old)
          break;
      end
      else if ((t > 0) && (t % PHASE_CLOCKS == 0))
      begin
        if (c_now)
          r.count_up = r.count_up + 1'b1;
        else
          r.count_down = r.count_down + 1'b1;
        done_phases++;
        m = c_now ? MUX_DOWN : MUX_UP;
        if (done_phases == phases)
          rundown = 1'b1;
        else
          m = m | MUX_INPUT;
      end
      level += mux_step(m, vin);
      hist.push_back(level > 0);
    end
    return r;
  endfunction

  //////////////////////////////////////////////////
  // SPI host and register access.
  //////////////////////////////////////////////////

  // mode 0 frame of nbits, each sclk level held for 4 clocks.
  task automatic spi_xfer(input logic [15:0] word, input int nbits, output logic [7:0] rx);
    rx = 8'h00;
    @(negedge clk);
    cs_n = 1'b0;
    for (int i = 0; i < nbits; i++)
    begin
      // word ends on the last bit, extra leading bits are zero.
      mosi = (nbits - 1 - i <= 15) ? word[nbits-1-i] : 1'b0;
      repeat (4) @(negedge clk);
      // read bits arrive on miso during the data byte.
      if ((i >= 8) && (i < 16))
        rx = {rx[6:0], miso};
      sclk = 1'b1;
      repeat (4) @(negedge clk);
      sclk = 1'b0;
    end
    repeat (4) @(negedge clk);
    cs_n = 1'b1;
    mosi = 1'b0;
    repeat (8) @(negedge clk);
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
    logic [7:0] unused;
    spi_xfer({addr, data}, 16, unused);
  endtask

  task automatic read_reg(input logic [7:0] addr, output logic [7:0] data);
    spi_xfer({addr, 8'h00}, 16, data);
  endtask

  task automatic wait_irq(input int max_clocks);
    int waited;
    waited = 0;
    while (!irq && (waited < max_clocks))
    begin
      @(negedge clk);
      waited++;
    end
    if (!irq)
    begin
      n_errors++;
      $display("no interrupt within %0d clocks of a conversion start", max_clocks);
    end
  endtask

  // model is cleared while the mux is idle, before the start frame.
  task automatic start_conversion(input int vin, input int phases, output conv_result_t exp);
    write_reg(ADDR_PHASES, 8'(phases));
    cur_vin = vin;
    acc     = 0;
    exp     = conv_expect(vin, phases);
    write_reg(ADDR_CTRL, 8'h01);
  endtask

  task automatic check_results(input conv_result_t exp, input int phases);
    logic [7:0]   lo;
    logic [7:0]   hi;
    conv_result_t got;
    read_reg(ADDR_UP_LO, lo);
    read_reg(ADDR_UP_HI, hi);
    got.count_up = {hi, lo};
    read_reg(ADDR_DOWN_LO, lo);
    read_reg(ADDR_DOWN_HI, hi);
    got.count_down = {hi, lo};
    read_reg(ADDR_RUNDOWN_LO, lo);
    read_reg(ADDR_RUNDOWN_HI, hi);
    got.count_rundown = {hi, lo};
    expect_value("count_up", got.count_up, exp.count_up);
    expect_value("count_down", got.count_down, exp.count_down);
    expect_value("count_rundown", got.count_rundown, exp.count_rundown);
    expect_value("up plus down", got.count_up + got.count_down, phases);
  endtask

  //////////////////////////////////////////////////
  // test sequence.
  //////////////////////////////////////////////////

  initial
  begin
    logic [7:0]   rx;
    logic [7:0]   data;
    logic [3:0]   led_exp;
    conv_result_t exp;
    int           vin;
    int           phases;
    void'($urandom(SEED));
    rst_n    = 1'b0;
    sclk     = 1'b0;
    cs_n     = 1'b1;
    mosi     = 1'b0;
    cmp      = 1'b0;
    acc      = 0;
    cur_vin  = 0;
    n_checks = 0;
    n_errors = 0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    repeat (4) @(negedge clk);

    // state after reset.
    expect_value("led after reset", led, 4'h0);
    expect_value("irq after reset", irq, 1'b0);
    expect_value("miso after reset", miso, 1'b0);
    expect_value("mux after reset", mux, MUX_IDLE);
    read_reg(ADDR_STATUS, rx);
    expect_value("status after reset", rx, 8'h00);

    // LED set, clear and toggle, then soft reset.
    led_exp = 4'h0;
    for (int i = 0; i < 12; i++)
    begin
      data = (i == 0) ? 8'hff : 8'($urandom);
      led_exp = led_update(led_exp, data);
      write_reg(ADDR_LED, data);
      expect_value("led port", led, led_exp);
      read_reg(ADDR_LED, rx);
      expect_value("led read", rx, {4'h0, led_exp});
    end
    write_reg(ADDR_LED_RESET, 8'h00);
    expect_value("led after soft reset", led, LED_RESET_VAL);

    // short and long frames are dropped.
    // if taken, each would end as a full write of led 1111 or phases 3.
    spi_xfer({ADDR_LED, 8'h0a}, 15, rx);
    spi_xfer({ADDR_LED, 8'h0a}, 17, rx);
    expect_value("led after bad frames", led, LED_RESET_VAL);
    spi_xfer({ADDR_PHASES, 8'h03}, 15, rx);
    spi_xfer({ADDR_PHASES, 8'h03}, 17, rx);
    spi_xfer({ADDR_PHASES, DEFAULT_PHASES}, 16, rx);
    expect_value("phases after bad frames", rx, DEFAULT_PHASES);

    // conversions, zero and full scale input first.
    for (int k = 0; k < 6; k++)
    begin
      if (k == 0)
        vin = 0;
      else if (k == 1)
        vin = VIN_MAX;
      else
        vin = int'($urandom_range(2 * VIN_MAX)) - VIN_MAX;
      phases = 1 + int'($urandom_range(MAX_PHASES - 1));
      start_conversion(vin, phases, exp);
      wait_irq(IRQ_WAIT);
      check_results(exp, phases);
      read_reg(ADDR_STATUS, rx);
      expect_value("status with result ready", rx, 8'h01);
      expect_value("irq after status read", irq, 1'b0);
    end

    // a start during a running conversion is ignored.
    start_conversion(-300, LONG_PHASES, exp);
    read_reg(ADDR_STATUS, rx);
    expect_value("status while busy", rx, 8'h02);
    write_reg(ADDR_CTRL, 8'h01);
    wait_irq(IRQ_WAIT);
    // busy must stay low right after the result.
    read_reg(ADDR_STATUS, rx);
    expect_value("status after long conversion", rx, 8'h01);
    expect_value("irq cleared", irq, 1'b0);
    check_results(exp, LONG_PHASES);
    repeat ((LONG_PHASES + 4) * PHASE_CLOCKS) @(negedge clk);
    expect_value("irq after ignored start", irq, 1'b0);
    read_reg(ADDR_STATUS, rx);
    expect_value("status after ignored start", rx, 8'h00);

    repeat (2) @(posedge clk);
    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule
